// ==== bench/lsu_store_tb.sv ====
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_store_tb;
    import lsu_pkg::*;

    localparam int RESET_CYCLES = 4;
    localparam int NSTIM        = 2000;
    localparam int LIMIT        = 20 * NSTIM;

    typedef struct {
        addr_t        addr;
        word_t        data;
        access_size_t size;
        logic         cache;
        logic         iss;
        int           serial;
    } st_entry_t;

    logic g;
    logic reset = 1'b1, req = 1'b0, load_req = 1'b0, cache = 1'b0;
    logic com = 1'b0, com1 = 1'b0, rb = 1'b0, bus_ready = 1'b0;
    addr_t addr = '0, lookup_addr = '0;
    word_t data = '0;
    access_size_t size = size_byte;
    store_id_t id = '0;
    logic busy, load_wait, bus_w, lookup_hit;
    addr_t bus_addr;
    word_t bus_data, lookup_data;
    access_size_t bus_size;

    // ************************************************************************
    // reference model state
    // ************************************************************************
    st_entry_t q[$];                        // oldest first
    int marked[$];                          // serials the last load waits on
    int ncom = 0, next_serial = 0;
    logic m_fill = 0, m_done = 0, m_hit = 0, m_fdone = 0, m_busw = 0;
    int m_cnt = 0;
    line_addr_t m_fline = '0;
    addr_t mb_addr;
    word_t mb_data;
    access_size_t mb_size;
    logic [7:0] mbytes [8][16];
    logic mvalid [8];
    line_addr_t mline [8];

    logic [31:0] rng = 32'd13;
    int cyc = 0, phase = 0, stim = 0, lk = 0, lk_cur = 0;

    tb_clock u_clk (.g(g));

    lsu_store i_dut (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic bit in_buffer(input int s);
        foreach (q[i])
            if (q[i].serial == s)
                return 1'b1;
        return 1'b0;
    endfunction

    task automatic fail_value(input string what, input logic [63:0] exp, input logic [63:0] act);
        $display("error: %s expected %0h actual %0h", what, exp, act);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic merge_store(input st_entry_t e);
        int k, base;
        k = e.addr[6:4];
        base = e.addr[3:2] * 4;
        case (e.size)
            size_byte: mbytes[k][base + e.addr[1:0]] = e.data[7:0];
            size_half:
            begin
                mbytes[k][base + e.addr[1]*2]     = e.data[7:0];
                mbytes[k][base + e.addr[1]*2 + 1] = e.data[15:8];
            end
            default:
                for (int b = 0; b < 4; b++)
                    mbytes[k][base + b] = e.data[b*8 +: 8];
        endcase
    endtask

    // one clock edge of the store unit, from the inputs sampled at that edge
    task automatic update_model();
        logic hr, issue, hit, fill_end, fin, refill, ucload, take;
        int k, keep[$];
        st_entry_t e;
        if (reset)
        begin
            q.delete();
            marked.delete();
            ncom = 0;
            {m_fill, m_done, m_hit, m_fdone, m_busw} = '0;
            foreach (mvalid[i])
                mvalid[i] = 1'b0;
            return;
        end
        hr       = q.size() > 0 && ncom > 0 && !q[0].iss;
        issue    = hr && q[0].cache && !m_fill;
        k        = hr ? q[0].addr[6:4] : 0;
        hit      = issue && mvalid[k] && mline[k] == q[0].addr[31:4];
        fill_end = m_fill && m_cnt == 0;
        fin      = q.size() > 0 && ((m_done && m_hit && q[0].cache) ||
                                    (m_busw && bus_ready && !q[0].cache));
        refill   = q.size() > 0 && m_fdone && m_fline == q[0].addr[31:4];
        ucload   = hr && !q[0].cache && !m_busw;
        take     = req && !(q.size() == `WBUF_DEPTH || rb);

        if (load_req)
        begin
            marked.delete();
            foreach (q[i])
                if (cache ? (q[i].cache && q[i].addr[31:2] == addr[31:2]) : !q[i].cache)
                    marked.push_back(q[i].serial);
        end
        else
        begin
            foreach (marked[i])
                if (in_buffer(marked[i]))
                    keep.push_back(marked[i]);
            marked = keep;
        end

        if (hit)
            merge_store(q[0]);
        if (issue && !hit)
        begin
            m_fill  = 1'b1;
            m_cnt   = `FILL_CYCLES - 1;
            m_fline = q[0].addr[31:4];
        end
        else if (fill_end)
        begin
            m_fill = 1'b0;
            mvalid[m_fline[2:0]] = 1'b1;    // fill brings a zero line
            mline[m_fline[2:0]]  = m_fline;
            for (int b = 0; b < 16; b++)
                mbytes[m_fline[2:0]][b] = 8'h00;
        end
        else if (m_fill)
            m_cnt--;
        m_done  = issue;
        m_hit   = hit;
        m_fdone = fill_end;

        if (m_busw && bus_ready)
            m_busw = 1'b0;
        else if (ucload)
        begin
            m_busw  = 1'b1;
            mb_addr = q[0].addr;
            mb_data = q[0].data;
            mb_size = q[0].size;
        end

        if (q.size() > 0 && refill)
            q[0].iss = 1'b0;
        else if (issue)
            q[0].iss = 1'b1;
        if (fin)
        begin
            void'(q.pop_front());
            ncom--;
        end

        if (rb)
            while (q.size() > ncom)
                void'(q.pop_back());
        else if (com && com1 && q.size() - ncom >= 2)
            ncom += 2;
        else if ((com || com1) && q.size() - ncom >= 1)
            ncom += 1;

        if (take)
        begin
            e = '{addr, data, size, cache, 1'b0, next_serial};
            next_serial++;
            q.push_back(e);
        end
    endtask

    task automatic drive_random();
        logic [31:0] r;
        logic [31:0] base;
        logic [1:0]  sz;
        r  = xorshift32(rng);
        rng = xorshift32(r);
        case (r[21:20])                     // two lines alias on each index
            2'd0: base = 32'h1000;
            2'd1: base = 32'h1010;
            2'd2: base = 32'h2000;
            default: base = 32'h3010;
        endcase
        sz = (r[19:18] == 2'd3) ? 2'd2 : r[19:18];
        rb       <= (r[5:0] == 6'd0);
        load_req <= (r[5:0] != 6'd0) && (r[9:6] == 4'd0);
        req      <= (r[5:0] != 6'd0) && (r[9:6] != 4'd0) && r[10];
        com      <= (q.size() - ncom >= 1) && r[11];
        com1     <= (q.size() - ncom >= 2) && r[11] && r[12];
        bus_ready <= (r[15:14] != 2'd0);
        cache    <= r[16] | r[17];
        size     <= access_size_t'(sz);
        id       <= r[31:25];
        data     <= rng;
        case (sz)
            2'd0: addr <= base + {r[23:22], r[25:24]};
            2'd1: addr <= base + {r[23:22], r[25], 1'b0};
            default: addr <= base + {r[23:22], 2'b00};
        endcase
    endtask

    // ************************************************************************
    // stimulus, one step per rising edge
    // ************************************************************************
    always @(posedge g)
    begin
        cyc++;
        if (cyc > LIMIT)
        begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("STATUS: FAIL");
            $fatal(1);
        end
        update_model();
        case (phase)
            0:
                if (cyc == RESET_CYCLES)
                begin
                    reset <= 1'b0;
                    phase = 1;
                end
            1:
            begin
                drive_random();
                stim++;
                if (stim == NSTIM)
                    phase = 2;
            end
            2:
            begin
                // drain everything that survives
                {req, load_req, rb, com1} <= '0;
                bus_ready <= 1'b1;
                com <= (q.size() - ncom >= 1);
                if (q.size() == 0 && !m_fill && !m_busw && !m_done)
                    phase = 3;
            end
            default:
                if (lk < 32)
                begin
                    lk_cur = lk;
                    lookup_addr <= {mline[lk / 4][27:3], 3'(lk / 4), 2'(lk % 4), 2'b00};
                    lk++;
                end
                else
                begin
                    $display("STATUS: PASS");
                    $finish;
                end
        endcase
    end

    // ************************************************************************
    // checks on the falling edge, where everything has settled
    // ************************************************************************
    always @(negedge g)
    begin
        if (phase >= 1)
        begin
            assert (busy == ((q.size() == `WBUF_DEPTH) || rb))
                else fail_value("busy", (q.size() == `WBUF_DEPTH) || rb, busy);
            assert (bus_w == m_busw) else fail_value("bus_w", m_busw, bus_w);
            if (m_busw)
            begin
                assert (bus_addr == mb_addr) else fail_value("bus_addr", mb_addr, bus_addr);
                assert (bus_data == mb_data) else fail_value("bus_data", mb_data, bus_data);
                assert (bus_size == mb_size) else fail_value("bus_size", mb_size, bus_size);
            end
            assert (load_wait == (marked.size() != 0))
                else fail_value("load_wait", marked.size() != 0, load_wait);
        end
        if (phase == 3 && lk > 0)
        begin
            assert (lookup_hit == mvalid[lk_cur / 4])
                else fail_value("lookup_hit", mvalid[lk_cur / 4], lookup_hit);
            if (mvalid[lk_cur / 4])
                assert (lookup_data == {mbytes[lk_cur / 4][(lk_cur % 4) * 4 + 3],
                                        mbytes[lk_cur / 4][(lk_cur % 4) * 4 + 2],
                                        mbytes[lk_cur / 4][(lk_cur % 4) * 4 + 1],
                                        mbytes[lk_cur / 4][(lk_cur % 4) * 4]})
                    else fail_value("lookup_data", {mbytes[lk_cur / 4][(lk_cur % 4) * 4 + 3],
                                                    mbytes[lk_cur / 4][(lk_cur % 4) * 4 + 2],
                                                    mbytes[lk_cur / 4][(lk_cur % 4) * 4 + 1],
                                                    mbytes[lk_cur / 4][(lk_cur % 4) * 4]},
                                    lookup_data);
        end
    end

endmodule

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic g
);

    initial
    begin
        g = 1'b0;
    end

    always #4 g = ~g;           // 8 ns period

endmodule

// ==== lsu_store.f ====
+incdir+source
source/lsu_pkg.sv
source/write_buffer.sv
source/dcache_writer.sv
source/uncached_port.sv
source/load_dependency.sv
source/lsu_store.sv
bench/tb_clock.sv
bench/lsu_store_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module lsu_store_tb \
    -f lsu_store.f -o lsu_store_sim

# the log decides pass or fail
./obj_dir/lsu_store_sim > sim.log 2>&1 || true
cat sim.log
grep -q "^STATUS: PASS$" sim.log

// ==== source/dcache_writer.sv ====
`timescale 1ns/1ps
`include "lsu_defines.svh"

module dcache_writer (
    input  logic                     g,
    input  logic                     reset,
    input  logic                     dc_w,
    input  lsu_pkg::addr_t           st_addr,
    input  lsu_pkg::word_t           st_data,
    input  lsu_pkg::access_size_t    st_size,
    input  lsu_pkg::addr_t           lookup_addr,
    output logic                     dc_ready,
    output logic                     dc_done,
    output logic                     dc_hit,
    output logic                     dc_fill_done,
    output lsu_pkg::line_addr_t      dc_fill_line,
    output logic                     lookup_hit,
    output lsu_pkg::word_t           lookup_data
);
    import lsu_pkg::*;

    localparam int IDX_BITS = $clog2(`DC_LINES);
    localparam int TAG_BITS = 28 - IDX_BITS;
    localparam int CNT_BITS = $clog2(`FILL_CYCLES + 1);

    logic [TAG_BITS-1:0]  tags  [`DC_LINES];
    logic [127:0]         lines [`DC_LINES];
    logic [`DC_LINES-1:0] tag_valid;

    fill_state_t         state;
    logic [CNT_BITS-1:0] fill_cnt;

    logic [IDX_BITS-1:0] st_idx, fill_idx, lk_idx;
    logic                st_hit, issue, fill_end;
    logic [3:0]          byte_en;
    word_t               lane_data, old_word, new_word;

    assign st_idx   = st_addr[4 +: IDX_BITS];
    assign fill_idx = dc_fill_line[IDX_BITS-1:0];
    assign st_hit   = tag_valid[st_idx] & (tags[st_idx] == st_addr[31 -: TAG_BITS]);
    assign dc_ready = (state == fill_idle);
    assign issue    = dc_w & dc_ready;
    assign fill_end = (state == fill_busy) & (fill_cnt == '0);

    // byte lanes touched by the store
    always_comb
    begin
        case (st_size)
            size_byte: byte_en = 4'b0001 << st_addr[1:0];
            size_half: byte_en = 4'b0011 << {st_addr[1], 1'b0};
            default:   byte_en = 4'b1111;
        endcase
        case (st_size)
            size_byte: lane_data = {4{st_data[7:0]}};
            size_half: lane_data = {2{st_data[15:0]}};
            default:   lane_data = st_data;
        endcase
        old_word = lines[st_idx][st_addr[3:2]*32 +: 32];
        for (int b = 0; b < 4; b++)
            new_word[b*8 +: 8] = byte_en[b] ? lane_data[b*8 +: 8] : old_word[b*8 +: 8];
    end

    always_ff @(posedge g)
    begin
        if (reset)
        begin
            state        <= fill_idle;
            fill_cnt     <= '0;
            tag_valid    <= '0;
            dc_done      <= 1'b0;
            dc_hit       <= 1'b0;
            dc_fill_done <= 1'b0;
            dc_fill_line <= '0;
        end
        else
        begin
            dc_done      <= issue;
            dc_hit       <= issue & st_hit;
            dc_fill_done <= fill_end;
            if (issue & ~st_hit)
            begin
                state        <= fill_busy;
                fill_cnt     <= CNT_BITS'(`FILL_CYCLES - 1);
                dc_fill_line <= st_addr[31:4];
            end
            else if (fill_end)
            begin
                state               <= fill_idle;
                tag_valid[fill_idx] <= 1'b1;
            end
            else if (state == fill_busy)
                fill_cnt <= fill_cnt - 1'b1;
        end
    end

    // arrays, fill brings in a zero line
    always_ff @(posedge g)
    begin
        if (fill_end)
        begin
            tags[fill_idx]  <= dc_fill_line[27 -: TAG_BITS];
            lines[fill_idx] <= '0;
        end
        else if (issue & st_hit)
            lines[st_idx][st_addr[3:2]*32 +: 32] <= new_word;
    end

    assign lk_idx      = lookup_addr[4 +: IDX_BITS];
    assign lookup_hit  = tag_valid[lk_idx] & (tags[lk_idx] == lookup_addr[31 -: TAG_BITS]);
    assign lookup_data = lines[lk_idx][lookup_addr[3:2]*32 +: 32];

endmodule

// ==== source/load_dependency.sv ====
`timescale 1ns/1ps

module load_dependency (
    input  logic                     g,
    input  logic                     reset,
    input  logic                     load_req,
    input  lsu_pkg::entry_mask_t     rely,
    input  lsu_pkg::entry_mask_t     cur,
    output logic                     load_wait
);
    import lsu_pkg::*;

    entry_mask_t mask;      // stores the last load still waits on

    // ************************************************************************
    // a new query replaces the mask, otherwise retired entries drop out
    // ************************************************************************

    always_ff @(posedge g)
    begin
        if (reset)
            mask <= '0;
        else if (load_req)
            mask <= rely;
        else
            mask <= mask & cur;
    end

    assign load_wait = |mask;

endmodule

// ==== source/lsu_defines.svh ====
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// write buffer geometry
`define WBUF_DEPTH    8
`define WBUF_PTR_BITS 3

// data cache geometry, 16-byte lines
`define DC_LINES      8

// line fill length in cycles
`define FILL_CYCLES   6

`endif

// ==== source/lsu_pkg.sv ====
package lsu_pkg;

`include "lsu_defines.svh"

    typedef logic [31:0] addr_t;                     // byte address
    typedef logic [31:0] word_t;                     // store datum
    typedef logic [27:0] line_addr_t;                // addr[31:4]
    typedef logic [6:0]  store_id_t;                 // instruction tag
    typedef logic [`WBUF_DEPTH-1:0] entry_mask_t;    // one bit per entry

    typedef enum logic [1:0] {
        size_byte,
        size_half,
        size_word
    } access_size_t;

    typedef enum logic {
        fill_idle,
        fill_busy
    } fill_state_t;

endpackage

// ==== source/lsu_store.sv ====
`timescale 1ns/1ps

module lsu_store (
    input  logic                     g,
    input  logic                     reset,
    input  logic                     req,
    input  logic                     load_req,
    input  lsu_pkg::addr_t           addr,
    input  lsu_pkg::word_t           data,
    input  lsu_pkg::access_size_t    size,
    input  lsu_pkg::store_id_t       id,
    input  logic                     cache,
    input  logic                     com,
    input  logic                     com1,
    input  logic                     rb,
    input  logic                     bus_ready,
    input  lsu_pkg::addr_t           lookup_addr,
    output logic                     busy,
    output logic                     load_wait,
    output logic                     bus_w,
    output lsu_pkg::addr_t           bus_addr,
    output lsu_pkg::word_t           bus_data,
    output lsu_pkg::access_size_t    bus_size,
    output logic                     lookup_hit,
    output lsu_pkg::word_t           lookup_data
);
    import lsu_pkg::*;

    // head of buffer, shared by the cache and uncached paths
    logic         dc_w, uc_w;
    addr_t        st_addr;
    word_t        st_data;
    access_size_t st_size;

    logic       dc_ready, dc_done, dc_hit, dc_fill_done;
    line_addr_t dc_fill_line;
    logic       uc_accept;

    entry_mask_t rely, cur;

    write_buffer u_wbuf (
        .g            (g),
        .reset        (reset),
        .req          (req),
        .addr         (addr),
        .data         (data),
        .size         (size),
        .id           (id),
        .cache        (cache),
        .com          (com),
        .com1         (com1),
        .rb           (rb),
        .dc_ready     (dc_ready),
        .dc_done      (dc_done),
        .dc_hit       (dc_hit),
        .dc_fill_done (dc_fill_done),
        .dc_fill_line (dc_fill_line),
        .uc_accept    (uc_accept),
        .busy         (busy),
        .dc_w         (dc_w),
        .uc_w         (uc_w),
        .st_addr      (st_addr),
        .st_data      (st_data),
        .st_size      (st_size),
        .rely         (rely),
        .cur          (cur)
    );

    dcache_writer u_dcache (
        .g            (g),
        .reset        (reset),
        .dc_w         (dc_w),
        .st_addr      (st_addr),
        .st_data      (st_data),
        .st_size      (st_size),
        .lookup_addr  (lookup_addr),
        .dc_ready     (dc_ready),
        .dc_done      (dc_done),
        .dc_hit       (dc_hit),
        .dc_fill_done (dc_fill_done),
        .dc_fill_line (dc_fill_line),
        .lookup_hit   (lookup_hit),
        .lookup_data  (lookup_data)
    );

    uncached_port u_uport (
        .g         (g),
        .reset     (reset),
        .uc_w      (uc_w),
        .st_addr   (st_addr),
        .st_data   (st_data),
        .st_size   (st_size),
        .bus_ready (bus_ready),
        .uc_accept (uc_accept),
        .bus_w     (bus_w),
        .bus_addr  (bus_addr),
        .bus_data  (bus_data),
        .bus_size  (bus_size)
    );

    load_dependency u_ldep (
        .g         (g),
        .reset     (reset),
        .load_req  (load_req),
        .rely      (rely),
        .cur       (cur),
        .load_wait (load_wait)
    );

endmodule

// ==== source/uncached_port.sv ====
`timescale 1ns/1ps

module uncached_port (
    input  logic                     g,
    input  logic                     reset,
    input  logic                     uc_w,
    input  lsu_pkg::addr_t           st_addr,
    input  lsu_pkg::word_t           st_data,
    input  lsu_pkg::access_size_t    st_size,
    input  logic                     bus_ready,
    output logic                     uc_accept,
    output logic                     bus_w,
    output lsu_pkg::addr_t           bus_addr,
    output lsu_pkg::word_t           bus_data,
    output lsu_pkg::access_size_t    bus_size
);

    logic load;

    // only pick up a store while the port is empty
    assign load      = uc_w & ~bus_w;
    assign uc_accept = bus_w & bus_ready;

    always_ff @(posedge g)
    begin
        if (reset)
            bus_w <= 1'b0;
        else if (uc_accept)
            bus_w <= 1'b0;          // buffer drops the entry on this edge
        else if (load)
            bus_w <= 1'b1;
    end

    // fields hold until the bus takes them
    always_ff @(posedge g)
    begin
        if (load)
        begin
            bus_addr <= st_addr;
            bus_data <= st_data;
            bus_size <= st_size;
        end
    end

endmodule

// ==== source/write_buffer.sv ====
`timescale 1ns/1ps
`include "lsu_defines.svh"

module write_buffer (
    input  logic                     g,
    input  logic                     reset,
    input  logic                     req,
    input  lsu_pkg::addr_t           addr,
    input  lsu_pkg::word_t           data,
    input  lsu_pkg::access_size_t    size,
    input  lsu_pkg::store_id_t       id,
    input  logic                     cache,
    input  logic                     com,
    input  logic                     com1,
    input  logic                     rb,
    input  logic                     dc_ready,
    input  logic                     dc_done,
    input  logic                     dc_hit,
    input  logic                     dc_fill_done,
    input  lsu_pkg::line_addr_t      dc_fill_line,
    input  logic                     uc_accept,
    output logic                     busy,
    output logic                     dc_w,
    output logic                     uc_w,
    output lsu_pkg::addr_t           st_addr,
    output lsu_pkg::word_t           st_data,
    output lsu_pkg::access_size_t    st_size,
    output lsu_pkg::entry_mask_t     rely,
    output lsu_pkg::entry_mask_t     cur
);
    import lsu_pkg::*;

    // per-entry control flags
    logic [`WBUF_DEPTH-1:0] valid;
    logic [`WBUF_DEPTH-1:0] comm;
    logic [`WBUF_DEPTH-1:0] issued;
    logic [`WBUF_DEPTH-1:0] cacheable;

    // per-entry payload
    store_id_t    ent_id   [`WBUF_DEPTH];
    addr_t        ent_addr [`WBUF_DEPTH];
    access_size_t ent_size [`WBUF_DEPTH];
    word_t        ent_data [`WBUF_DEPTH];

    logic [`WBUF_PTR_BITS-1:0] wptr, cptr, cptr1, fptr;

    logic take;
    logic do_com, do_dcom;
    logic single_ok, double_ok;
    logic finish;
    logic head_ready;
    logic refill;

    assign take      = req & ~busy;
    assign do_com    = (com | com1) & ~rb;
    assign do_dcom   = com & com1 & ~rb;
    assign double_ok = do_dcom & valid[cptr] & valid[cptr1];
    assign single_ok = do_com & valid[cptr];

    // head entry leaves on a cache hit or on uncached acceptance
    assign finish = valid[fptr] &
                    ((dc_done & dc_hit & cacheable[fptr]) | (uc_accept & ~cacheable[fptr]));

    assign refill = dc_fill_done & (dc_fill_line == ent_addr[fptr][31:4]);

    // ************************************************************************
    // pointers
    // ************************************************************************

    always_ff @(posedge g)
    begin
        if (reset)
            wptr <= '0;
        else if (rb)
            wptr <= cptr;               // drop everything past the commit point
        else if (take)
            wptr <= wptr + 1'b1;
    end

    always_ff @(posedge g)
    begin
        if (reset)
        begin
            cptr  <= '0;
            cptr1 <= `WBUF_PTR_BITS'(1);
        end
        else if (double_ok)
        begin
            cptr  <= cptr + `WBUF_PTR_BITS'(2);
            cptr1 <= cptr + `WBUF_PTR_BITS'(3);
        end
        else if (single_ok)
        begin
            cptr  <= cptr + `WBUF_PTR_BITS'(1);
            cptr1 <= cptr + `WBUF_PTR_BITS'(2);
        end
    end

    always_ff @(posedge g)
    begin
        if (reset)
            fptr <= '0;
        else if (finish)
            fptr <= fptr + 1'b1;
    end

    // ************************************************************************
    // entries
    // ************************************************************************

    for (genvar i = 0; i < `WBUF_DEPTH; i++)
    begin : g_entry
        logic wr_here;
        assign wr_here = take & (wptr == i);

        always_ff @(posedge g)
        begin
            if (reset)
            begin
                valid[i]  <= 1'b0;
                comm[i]   <= 1'b0;
                issued[i] <= 1'b0;
            end
            else
            begin
                if (rb & ~comm[i])
                    valid[i] <= 1'b0;
                else if (finish & (fptr == i))
                    valid[i] <= 1'b0;
                else if (wr_here)
                    valid[i] <= 1'b1;

                if (wr_here)
                    comm[i] <= 1'b0;
                else if ((double_ok & (cptr1 == i)) | (single_ok & (cptr == i)))
                    comm[i] <= 1'b1;

                if (wr_here)
                    issued[i] <= 1'b0;
                else if (refill & (fptr == i))
                    issued[i] <= 1'b0;      // line is in so reissue
                else if (dc_w & dc_ready & (fptr == i))
                    issued[i] <= 1'b1;
            end
        end

        always_ff @(posedge g)
        begin
            if (wr_here)
            begin
                ent_id[i]    <= id;
                ent_addr[i]  <= addr;
                ent_size[i]  <= size;
                ent_data[i]  <= data;
                cacheable[i] <= cache;
            end
        end

        // stores a load on addr must wait behind
        assign rely[i] = cache ?
            (valid[i] & cacheable[i] & (ent_addr[i][31:2] == addr[31:2])) :
            (valid[i] & ~cacheable[i]);
        assign cur[i] = valid[i];
    end

    assign busy = valid[wptr] | rb;

    assign head_ready = valid[fptr] & comm[fptr] & ~issued[fptr];
    assign dc_w    = head_ready & cacheable[fptr];
    assign uc_w    = head_ready & ~cacheable[fptr];
    assign st_addr = ent_addr[fptr];
    assign st_data = ent_data[fptr];
    assign st_size = ent_size[fptr];

endmodule
